// File: verilog.f
common/mext_pkg.sv
hw/mext_decode.sv
mul/mul_shift_add.sv
div/div_restoring.sv
hw/mext_result.sv
hw/mext_unit.sv
verif/mext_tb.sv

// File: verif/mext_tb.sv
`timescale 1ns/1ps

module mext_tb;
	import mext_pkg::*;

	// 6 tests of up to 100 ops at 70 cycles plus margin
	localparam int max_cycles = 45000;
	localparam int normal_lat = 66;
	localparam int special_lat = 2;
	localparam logic [63:0] most_neg = 64'h8000_0000_0000_0000;

	logic clk;
	logic reset;
	logic flush;
	logic req_valid;
	mext_req_t req;
	logic req_ready;
	mext_resp_t resp;

	integer seed = 18;
	int cycle_count;
	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;
	string test_name;

	mext_op_t mul_ops [4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
	mext_op_t div_ops [8] = '{op_div, op_divu, op_rem, op_remu,
		op_divw, op_divuw, op_remw, op_remuw};

	mext_unit u_mext_unit (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run stopped after %0d cycles", max_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [63:0] sext_word(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	// RV64M reference
	function automatic logic [63:0] model(input mext_op_t op, input logic [63:0] a,
		input logic [63:0] b);
		logic [127:0] ua, ub, up, sp, sup;
		logic signed [127:0] sa, sb;
		logic signed [63:0] sa64, sb64, r64;
		logic signed [31:0] sa32, sb32, r32;
		logic [31:0] wa, wb;
		ua = {64'd0, a};
		ub = {64'd0, b};
		sa = {{64{a[63]}}, a};
		sb = {{64{b[63]}}, b};
		up = ua * ub;
		sp = sa * sb;
		sup = sa * ub; // signed a times unsigned b mod 2^128
		sa64 = a;
		sb64 = b;
		wa = a[31:0];
		wb = b[31:0];
		sa32 = wa;
		sb32 = wb;
		case (op)
			op_mul: return up[63:0];
			op_mulh: return sp[127:64];
			op_mulhsu: return sup[127:64];
			op_mulhu: return up[127:64];
			op_mulw: return sext_word(up[31:0]);
			op_div, op_rem: begin
				if (b == 64'd0)
					return (op == op_div) ? '1 : a;
				if (a == most_neg && b == '1)
					return (op == op_div) ? a : 64'd0;
				r64 = (op == op_div) ? sa64 / sb64 : sa64 % sb64;
				return r64;
			end
			op_divu: return (b == 64'd0) ? '1 : a / b;
			op_remu: return (b == 64'd0) ? a : a % b;
			op_divw, op_remw: begin
				if (wb == 32'd0)
					return (op == op_divw) ? '1 : sext_word(wa);
				if (wa == 32'h8000_0000 && wb == 32'hffff_ffff)
					return (op == op_divw) ? sext_word(wa) : 64'd0;
				r32 = (op == op_divw) ? sa32 / sb32 : sa32 % sb32;
				return sext_word(r32);
			end
			op_divuw: return (wb == 32'd0) ? '1 : sext_word(wa / wb);
			op_remuw: return (wb == 32'd0) ? sext_word(wa) : sext_word(wa % wb);
			default: return 64'd0;
		endcase
	endfunction

	// zero divisor or signed overflow bypasses the execute blocks
	function automatic int expected_latency(input mext_op_t op, input logic [63:0] a,
		input logic [63:0] b);
		logic bypass;
		case (op)
			op_div, op_rem: bypass = (b == 64'd0) || (a == most_neg && b == '1);
			op_divu, op_remu: bypass = (b == 64'd0);
			op_divw, op_remw: bypass = (b[31:0] == 32'd0) ||
				(a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
			op_divuw, op_remuw: bypass = (b[31:0] == 32'd0);
			default: bypass = 1'b0;
		endcase
		return bypass ? special_lat : normal_lat;
	endfunction

	// leans toward zero, minus one and most negative values
	function automatic logic [63:0] pick_operand();
		int unsigned sel;
		sel = $unsigned($random(seed)) % 8;
		case (sel)
			0: return 64'd0;
			1: return '1;
			2: return most_neg;
			3: return {$random(seed), 32'h8000_0000};
			4: return {$random(seed), 32'hffff_ffff};
			5: return {59'd0, 5'($random(seed))};
			default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	function automatic mext_op_t any_op();
		return mext_op_t'($unsigned($random(seed)) % 13);
	endfunction

	task automatic check_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test(input int ops);
		if (test_errors == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %s: %0d operations, %0d errors", test_name, ops, test_errors);
	endtask

	task automatic idle_check(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			check_value("ready while idle", 64'd1, 64'(req_ready));
			check_value("stray response", 64'd0, 64'(resp.valid));
		end
	endtask

	task automatic do_op(input mext_op_t op, input logic [63:0] a, input logic [63:0] b,
		input bit offer_busy);
		logic [63:0] exp_data;
		int exp_lat;
		int cycles;
		bit seen;
		exp_data = model(op, a, b);
		exp_lat = expected_latency(op, a, b);
		check_value("ready before request", 64'd1, 64'(req_ready));
		req_valid = 1'b1;
		req.op = op;
		req.a = a;
		req.b = b;
		@(posedge clk); // accepting edge
		#1;
		if (offer_busy) begin
			req.op = any_op(); // must not be taken
			req.a = pick_operand();
			req.b = pick_operand();
		end else
			req_valid = 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles <= 100) begin
			check_value("ready while busy", 64'd0, 64'(req_ready));
			@(posedge clk);
			#1;
			cycles++;
			seen = resp.valid;
		end
		assert (seen) else begin
			$display("%s: %s request never got a response", test_name, op.name());
			test_errors++;
			total_errors++;
		end
		if (seen) begin
			check_value($sformatf("%s result", op.name()), exp_data, resp.data);
			check_value($sformatf("%s latency", op.name()), 64'(exp_lat), 64'(cycles));
			check_value("ready at response", 64'd0, 64'(req_ready));
			@(posedge clk);
			#1;
			check_value("ready after response", 64'd1, 64'(req_ready));
			check_value("valid width", 64'd0, 64'(resp.valid));
		end
		req_valid = 1'b0;
	endtask

	initial begin
		mext_op_t op;
		logic [63:0] a;
		logic [63:0] b;
		int wait_n;
		reset = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		cycle_count = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test("handshake");
		check_value("ready after reset", 64'd1, 64'(req_ready));
		check_value("valid after reset", 64'd0, 64'(resp.valid));
		for (int i = 0; i < 20; i++) begin
			do_op(any_op(), pick_operand(), pick_operand(), 1'b1);
			idle_check(2);
		end
		idle_check(80); // long enough for a wrongly taken request to answer
		finish_test(20);

		begin_test("mul_family");
		for (int i = 0; i < 100; i++)
			do_op(mul_ops[$unsigned($random(seed)) % 4], pick_operand(), pick_operand(), 1'b0);
		finish_test(100);

		begin_test("mul_word");
		for (int i = 0; i < 60; i++)
			do_op(op_mulw, pick_operand(), pick_operand(), 1'b0);
		finish_test(60);

		begin_test("div_family");
		for (int i = 0; i < 100; i++)
			do_op(div_ops[$unsigned($random(seed)) % 8], pick_operand(), pick_operand(), 1'b0);
		finish_test(100);

		begin_test("special_cases");
		for (int i = 0; i < 40; i++) begin
			op = div_ops[$unsigned($random(seed)) % 8];
			a = pick_operand();
			b = {$random(seed), 32'd0}; // upper half ignored by word forms
			if (op < op_divw)
				b = 64'd0;
			if ((op == op_div || op == op_rem) && $random(seed) % 2 == 0) begin
				a = most_neg;
				b = '1;
			end else if ((op == op_divw || op == op_remw) && $random(seed) % 2 == 0) begin
				a = {$random(seed), 32'h8000_0000};
				b = {$random(seed), 32'hffff_ffff};
			end
			do_op(op, a, b, 1'b0);
		end
		finish_test(40);

		begin_test("flush");
		for (int i = 0; i < 20; i++) begin
			op = any_op();
			a = pick_operand();
			b = pick_operand();
			if (expected_latency(op, a, b) == special_lat)
				b = 64'd7;
			check_value("ready before request", 64'd1, 64'(req_ready));
			req_valid = 1'b1;
			req.op = op;
			req.a = a;
			req.b = b;
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			wait_n = 3 + $unsigned($random(seed)) % 50; // well before done
			repeat (wait_n) begin
				@(posedge clk);
				#1;
				check_value("response before flush", 64'd0, 64'(resp.valid));
			end
			flush = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
			check_value("ready after flush", 64'd1, 64'(req_ready));
			idle_check(70);
			do_op(any_op(), pick_operand(), pick_operand(), 1'b0);
		end
		finish_test(40);

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0 && total_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: hw/mext_unit.sv
`timescale 1ns/1ps

module mext_unit (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic req_valid,
	input mext_pkg::mext_req_t req,
	output logic req_ready,
	output mext_pkg::mext_resp_t resp
);
	import mext_pkg::*;

	mext_cmd_t cmd;
	logic mul_start;
	logic div_start;
	logic special_start;
	logic mul_done;
	logic div_done;
	logic [prod_w-1:0] product;
	logic [xlen-1:0] quotient;
	logic [xlen-1:0] remainder;

	mext_decode u_decode (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.cmd(cmd),
		.mul_start(mul_start),
		.div_start(div_start),
		.special_start(special_start),
		.resp_seen(resp.valid) // back to idle on response
	);

	mul_shift_add u_mul (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.start(mul_start),
		.multiplicand(cmd.a_mag),
		.multiplier(cmd.b_mag),
		.product(product),
		.done(mul_done)
	);

	div_restoring u_div (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.start(div_start),
		.dividend(cmd.a_mag),
		.divisor(cmd.b_mag),
		.quotient(quotient),
		.remainder(remainder),
		.done(div_done)
	);

	mext_result u_result (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.mul_done(mul_done),
		.div_done(div_done),
		.special_start(special_start),
		.product(product),
		.quotient(quotient),
		.remainder(remainder),
		.resp(resp)
	);

endmodule

// File: hw/mext_result.sv
`timescale 1ns/1ps

module mext_result (
	input logic clk,
	input logic reset,
	input mext_pkg::mext_cmd_t cmd,
	input logic mul_done,
	input logic div_done,
	input logic special_start,
	input logic [127:0] product,
	input logic [63:0] quotient,
	input logic [63:0] remainder,
	output mext_pkg::mext_resp_t resp
);
	import mext_pkg::*;

	logic [prod_w-1:0] prod_fix;
	logic [xlen-1:0] quot_fix;
	logic [xlen-1:0] rem_fix;
	logic [xlen-1:0] sel;
	logic [xlen-1:0] final_val;
	logic fire;
	logic valid_q;
	logic [xlen-1:0] data_q;

	assign fire = mul_done | div_done | special_start;

	always_comb begin
		prod_fix = cmd.neg_main ? (~product + 1'b1) : product;
		quot_fix = cmd.neg_main ? (~quotient + 1'b1) : quotient;
		rem_fix = cmd.neg_rem ? (~remainder + 1'b1) : remainder;
		if (special_start)
			sel = cmd.special_val;
		else if (div_done)
			sel = cmd.take_rem ? rem_fix : quot_fix;
		else
			sel = cmd.take_high ? prod_fix[prod_w-1:xlen] : prod_fix[xlen-1:0];
		final_val = cmd.word ? {{32{sel[31]}}, sel[31:0]} : sel; // w forms
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= fire; // one cycle pulse
	end

	always_ff @(posedge clk) begin
		if (fire)
			data_q <= final_val;
	end

	assign resp.valid = valid_q;
	assign resp.data = data_q;

endmodule

// File: div/div_restoring.sv
`timescale 1ns/1ps

module div_restoring (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic start,
	input logic [63:0] dividend,
	input logic [63:0] divisor,
	output logic [63:0] quotient,
	output logic [63:0] remainder,
	output logic done
);
	import mext_pkg::*;

	logic busy;
	logic [cnt_w-1:0] count;
	logic [xlen-1:0] rem_q;
	logic [xlen-1:0] rem_cur;
	logic [xlen-1:0] quot_q;
	logic [xlen-1:0] quot_cur;
	logic [xlen:0] rem_shift;
	logic [xlen:0] diff;
	logic borrow;

	// quotient register doubles as the dividend shifter
	assign rem_cur = start ? {xlen{1'b0}} : rem_q;
	assign quot_cur = start ? dividend : quot_q;

	assign rem_shift = {rem_cur, quot_cur[xlen-1]};
	assign diff = rem_shift - {1'b0, divisor}; // divisor stable from decode
	assign borrow = diff[xlen];

	always_ff @(posedge clk) begin
		if (start || busy) begin
			rem_q <= borrow ? rem_shift[xlen-1:0] : diff[xlen-1:0]; // restore on borrow
			quot_q <= {quot_cur[xlen-2:0], ~borrow};
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			busy <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= cnt_w'(1);
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == cnt_w'(iter_count - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	assign quotient = quot_q;
	assign remainder = rem_q;

endmodule

// File: mul/mul_shift_add.sv
`timescale 1ns/1ps

module mul_shift_add (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic start,
	input logic [63:0] multiplicand,
	input logic [63:0] multiplier,
	output logic [127:0] product,
	output logic done
);
	import mext_pkg::*;

	logic busy;
	logic [cnt_w-1:0] count;
	logic [prod_w-1:0] acc;
	logic [prod_w-1:0] acc_cur;
	logic [prod_w-1:0] cand_q;
	logic [prod_w-1:0] cand_cur;
	logic [prod_w-1:0] addend;
	logic [xlen-1:0] plier_q;
	logic [xlen-1:0] plier_cur;

	// first iteration runs straight off the inputs
	assign cand_cur = start ? {{xlen{1'b0}}, multiplicand} : cand_q;
	assign plier_cur = start ? multiplier : plier_q;
	assign acc_cur = start ? {prod_w{1'b0}} : acc;

	assign addend = plier_cur[0] ? cand_cur : {prod_w{1'b0}};

	// add and shift in the same cycle
	always_ff @(posedge clk) begin
		if (start || busy) begin
			acc <= acc_cur + addend;
			cand_q <= cand_cur << 1;
			plier_q <= plier_cur >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			busy <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= cnt_w'(1);
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == cnt_w'(iter_count - 1)) begin
					busy <= 1'b0; // last bit of multiplier
					done <= 1'b1;
				end
			end
		end
	end

	assign product = acc;

endmodule

// File: hw/mext_decode.sv
`timescale 1ns/1ps

module mext_decode (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic req_valid,
	input mext_pkg::mext_req_t req,
	output logic req_ready,
	output mext_pkg::mext_cmd_t cmd,
	output logic mul_start,
	output logic div_start,
	output logic special_start,
	input logic resp_seen
);
	import mext_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_busy
	} state_t;

	state_t state;
	logic accept;
	logic [5:0] flags;
	logic a_signed, b_signed, is_div, take_high, take_rem, word;
	logic [xlen-1:0] a_ext, b_ext;
	logic a_neg, b_neg;
	logic div_zero, overflow;
	mext_cmd_t next_cmd;

	assign req_ready = (state == st_idle);
	assign accept = req_valid && req_ready;

	// a signed, b signed, div, high, rem, word
	always_comb begin
		case (req.op)
			op_mulh: flags = 6'b110100;
			op_mulhsu: flags = 6'b100100;
			op_mulhu: flags = 6'b000100;
			op_mulw: flags = 6'b000001;
			op_div: flags = 6'b111000;
			op_divu: flags = 6'b001000;
			op_rem: flags = 6'b111010;
			op_remu: flags = 6'b001010;
			op_divw: flags = 6'b111001;
			op_divuw: flags = 6'b001001;
			op_remw: flags = 6'b111011;
			op_remuw: flags = 6'b001011;
			default: flags = 6'b000000; // mul low half is sign agnostic
		endcase
	end

	assign {a_signed, b_signed, is_div, take_high, take_rem, word} = flags;

	assign a_ext = word ? {{32{a_signed & req.a[31]}}, req.a[31:0]} : req.a;
	assign b_ext = word ? {{32{b_signed & req.b[31]}}, req.b[31:0]} : req.b;
	assign a_neg = a_signed & a_ext[xlen-1];
	assign b_neg = b_signed & b_ext[xlen-1];

	assign div_zero = is_div && (b_ext == '0);
	assign overflow = is_div && a_signed && (&b_ext) && (a_ext == (word ? min_word : min_dword));

	always_comb begin
		next_cmd.a_mag = a_neg ? (~a_ext + 1'b1) : a_ext;
		next_cmd.b_mag = b_neg ? (~b_ext + 1'b1) : b_ext;
		next_cmd.is_div = is_div;
		next_cmd.neg_main = a_neg ^ b_neg;
		next_cmd.neg_rem = a_neg;
		next_cmd.take_high = take_high;
		next_cmd.take_rem = take_rem;
		next_cmd.word = word;
		next_cmd.special = div_zero | overflow;
		if (div_zero)
			next_cmd.special_val = take_rem ? a_ext : '1;
		else
			next_cmd.special_val = take_rem ? '0 : a_ext; // overflow
	end

	always_ff @(posedge clk) begin
		if (accept)
			cmd <= next_cmd; // held until the response
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state <= st_idle;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			special_start <= 1'b0;
		end else begin
			mul_start <= 1'b0;
			div_start <= 1'b0;
			special_start <= 1'b0;
			case (state)
				st_idle: if (accept) state <= st_issue;
				st_issue: begin
					mul_start <= !cmd.special && !cmd.is_div;
					div_start <= !cmd.special && cmd.is_div;
					special_start <= cmd.special;
					state <= st_busy;
				end
				st_busy: if (resp_seen) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: common/mext_pkg.sv
package mext_pkg;

	localparam int xlen = 64;
	localparam int prod_w = 2 * xlen;
	localparam int iter_count = 64; // one bit per cycle
	localparam int cnt_w = $clog2(iter_count);

	// most negative dividends for the overflow check
	localparam logic [xlen-1:0] min_dword = {1'b1, {(xlen-1){1'b0}}};
	localparam logic [xlen-1:0] min_word = {{(xlen-31){1'b1}}, {31{1'b0}}}; // sign-extended

	typedef enum logic [3:0] {
		op_mul = 4'd0,
		op_mulh = 4'd1,
		op_mulhsu = 4'd2,
		op_mulhu = 4'd3,
		op_mulw = 4'd4,
		op_div = 4'd5,
		op_divu = 4'd6,
		op_rem = 4'd7,
		op_remu = 4'd8,
		op_divw = 4'd9,
		op_divuw = 4'd10,
		op_remw = 4'd11,
		op_remuw = 4'd12
	} mext_op_t;

	typedef struct packed {
		mext_op_t op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
	} mext_req_t;

	typedef struct packed {
		logic [xlen-1:0] a_mag;
		logic [xlen-1:0] b_mag;
		logic is_div; // divider, else multiplier
		logic neg_main; // product or quotient sign
		logic neg_rem; // remainder follows dividend
		logic take_high;
		logic take_rem;
		logic word; // sign-extend from bit 31
		logic special; // no execute pass
		logic [xlen-1:0] special_val;
	} mext_cmd_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] data;
	} mext_resp_t;

endpackage
